// File: dv/tb_rv32_core_slice.sv
`timescale 1ns/1ns

module tb_rv32_core_slice
  import rv32_pkg::*;
();

  localparam int          XLEN       = 32;
  localparam int          RAS_DEPTH  = 4;
  localparam logic [15:0] SEED       = 16'd6189;
  localparam logic [31:0] MRET_INSTR = 32'h3020_0073;

  logic        clk_i;
  logic        rst_n_i;
  logic [31:0] instr_i;
  logic [31:0] pc_i;
  logic        valid_i;
  logic        clear_i;
  logic        irq_i;
  exec_out_t   result_o;
  logic [31:0] uepc_o;

  logic [15:0] lfsr = SEED;
  logic [31:0] regs_m [32];         // Architectural registers
  logic [31:0] ras_m [RAS_DEPTH];
  int          ras_top_m;
  int          ras_cnt_m;
  logic [31:0] uepc_m;
  logic [31:0] pc_cur = 32'h0000_1000;
  exec_out_t   exp_q [$];
  string       name_q [$];
  string       cur_test;
  logic        accept_q = 1'b0;
  logic        due_q = 1'b0;
  int          checks = 0;
  int          test_errs = 0;
  int          total_errs = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  rv32_core_slice #(.XLEN(XLEN), .RAS_DEPTH(RAS_DEPTH)) dut (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .instr_i  (instr_i),
    .pc_i     (pc_i),
    .valid_i  (valid_i),
    .clear_i  (clear_i),
    .irq_i    (irq_i),
    .result_o (result_o),
    .uepc_o   (uepc_o)
  );

  always #2 clk_i = ~clk_i;

  // Taps at x^16 + x^14 + x^13 + x^11 + 1 with one step per bit
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP, 2'b11};
  endfunction

  function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, opcode_e opc);
    return {imm, rs1, f3, rd, opc, 2'b11};
  endfunction

  function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE, 2'b11};
  endfunction

  function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH, 2'b11};
  endfunction

  function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] rd, opcode_e opc);
    return {imm, rd, opc, 2'b11};
  endfunction

  function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL, 2'b11};
  endfunction

  function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                          logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5:
      begin
        if (alt)
          return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [31:0] mul_ref(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    logic [63:0] xa;
    logic [63:0] xb;
    logic [63:0] p;
    xa = {{32{a[31]}}, a};
    xb = {{32{b[31]}}, b};
    if (f3 == 3'd3)
      xa = {32'd0, a};   // MULHU
    if (f3 >= 3'd2)
      xb = {32'd0, b};   // MULHSU and MULHU
    p = xa * xb;
    return (f3 == 3'd0) ? p[31:0] : p[63:32];
  endfunction

  function automatic logic branch_ref(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic is_link(logic [4:0] r);
    return (r == 5'd1) || (r == 5'd5);
  endfunction

  // Fields without meaning for this result are zeroed
  function automatic exec_out_t keep_live(exec_out_t r);
    if (!r.wb_valid)
    begin
      r.wb_rd   = '0;
      r.wb_data = '0;
    end
    if (!r.redirect)
      r.redirect_pc = '0;
    if (!r.mem_req)
    begin
      r.mem_addr = '0;
      r.mem_size = '0;
    end
    if (!r.mem_write)
      r.mem_wdata = '0;
    return r;
  endfunction

  // Expected result that also steps the register and stack model
  function automatic exec_out_t predict(logic [31:0] ins, logic [31:0] pc);
    exec_out_t   e;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] top;
    logic        writes;
    logic        push;
    logic        pop;
    e      = '0;
    writes = 1'b0;
    push   = 1'b0;
    pop    = 1'b0;
    rd     = ins[11:7];
    f3     = ins[14:12];
    a      = regs_m[ins[19:15]];
    b      = regs_m[ins[24:20]];
    imm_i  = {{20{ins[31]}}, ins[31:20]};
    top    = (ras_cnt_m == 0) ? '0 : ras_m[ras_top_m];
    case (opcode_e'(ins[6:2]))
      OPC_OP:
      begin
        writes    = 1'b1;
        e.wb_data = ins[25] ? mul_ref(f3, a, b) : alu_ref(f3, ins[30], a, b);
      end
      OPC_OP_IMM:
      begin
        writes    = 1'b1;
        e.wb_data = alu_ref(f3, ins[30] && (f3 == 3'd5), a, imm_i);
      end
      OPC_LUI:
      begin
        writes    = 1'b1;
        e.wb_data = {ins[31:12], 12'd0};
      end
      OPC_AUIPC:
      begin
        writes    = 1'b1;
        e.wb_data = pc + {ins[31:12], 12'd0};
      end
      OPC_BRANCH:
      begin
        e.redirect    = branch_ref(f3, a, b);
        e.redirect_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      OPC_JAL:
      begin
        writes        = 1'b1;
        e.wb_data     = pc + 32'd4;
        e.redirect    = 1'b1;
        e.redirect_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        push          = is_link(rd);
      end
      OPC_JALR:
      begin
        writes        = 1'b1;
        e.wb_data     = pc + 32'd4;
        e.redirect_pc = (a + imm_i) & ~32'd1;
        e.mispredict  = (top != e.redirect_pc);
        e.redirect    = e.mispredict;
        push          = is_link(rd);
        pop           = is_link(ins[19:15]) && !(push && (rd == ins[19:15]));
      end
      OPC_LOAD:
      begin
        e.mem_req  = 1'b1;
        e.mem_addr = a + imm_i;
        e.mem_size = f3;
      end
      OPC_STORE:
      begin
        e.mem_req   = 1'b1;
        e.mem_write = 1'b1;
        e.mem_addr  = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        e.mem_wdata = b;
        e.mem_size  = f3;
      end
      OPC_SYSTEM:
      begin
        e.redirect    = (ins == MRET_INSTR);
        e.redirect_pc = uepc_m;
      end
      default: ;
    endcase
    e.wb_valid = writes && (rd != 5'd0);
    e.wb_rd    = rd;
    if (e.wb_valid)
      regs_m[rd] = e.wb_data;
    if (push && pop)
    begin
      ras_m[ras_top_m] = pc + 32'd4;  // Replace top
      if (ras_cnt_m == 0)
        ras_cnt_m = 1;
    end
    else if (push)
    begin
      ras_top_m        = (ras_top_m + 1) % RAS_DEPTH;
      ras_m[ras_top_m] = pc + 32'd4;
      if (ras_cnt_m < RAS_DEPTH)
        ras_cnt_m++;
    end
    else if (pop && (ras_cnt_m > 0))
    begin
      ras_top_m = (ras_top_m + RAS_DEPTH - 1) % RAS_DEPTH;
      ras_cnt_m--;
    end
    return keep_live(e);
  endfunction

  function automatic logic [31:0] random_alu();
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        alt;
    logic [11:0] imm;
    f3  = 3'(rand_bits(3));
    rd  = 5'(rand_bits(3));  // Small register set so results feed each other
    rs1 = 5'(rand_bits(3));
    rs2 = 5'(rand_bits(3));
    alt = rand_bits(1) && ((f3 == 3'd0) || (f3 == 3'd5));
    imm = 12'(rand_bits(12));
    if (rand_bits(1))
      return r_type({1'b0, alt, 5'd0}, rs2, rs1, f3, rd);
    if ((f3 == 3'd1) || (f3 == 3'd5))
      imm = {1'b0, alt, 5'd0, imm[4:0]};
    return i_type(imm, rs1, f3, rd, OPC_OP_IMM);
  endfunction

  task automatic note_error();
    test_errs++;
    total_errs++;
  endtask

  task automatic issue(input logic [31:0] ins);
    @(negedge clk_i);
    instr_i = ins;
    pc_i    = pc_cur;
    valid_i = 1'b1;
    clear_i = 1'b0;
    irq_i   = 1'b0;
    exp_q.push_back(predict(ins, pc_cur));
    name_q.push_back(cur_test);
    pc_cur = pc_cur + 32'd4;
  endtask

  task automatic issue_cleared(input logic [31:0] ins);
    @(negedge clk_i);
    instr_i = ins;
    pc_i    = pc_cur;
    valid_i = 1'b1;
    clear_i = 1'b1;
    pc_cur  = pc_cur + 32'd4;
  endtask

  task automatic load_random(input logic [4:0] rd);
    issue(u_type(20'(rand_bits(20)), rd, OPC_LUI));
    issue(i_type(12'(rand_bits(12)), rd, 3'd0, rd, OPC_OP_IMM));
  endtask

  task automatic raise_irq(input logic [31:0] pc);
    @(negedge clk_i);
    valid_i = 1'b0;
    clear_i = 1'b0;
    irq_i   = 1'b1;
    pc_i    = pc;
    uepc_m  = pc;
    @(negedge clk_i);
    irq_i = 1'b0;
    checks++;
    if (uepc_o !== pc)
    begin
      $display("error %s: expected uepc %h actual %h", cur_test, pc, uepc_o);
      note_error();
    end
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic finish_test();
    int waited;
    waited = 0;
    @(negedge clk_i);
    valid_i = 1'b0;
    clear_i = 1'b0;
    irq_i   = 1'b0;
    while ((exp_q.size() != 0) && (waited < 16))
    begin
      @(negedge clk_i);
      waited++;
    end
    if (exp_q.size() != 0)
    begin
      $display("%s timed out, %0d results never came out", cur_test, exp_q.size());
      note_error();
      exp_q.delete();
      name_q.delete();
    end
    repeat (2) @(negedge clk_i);
    tests_run++;
    if (test_errs == 0)
      $display("test %s passed", cur_test);
    else
    begin
      $display("test %s failed with %0d errors", cur_test, test_errs);
      tests_failed++;
    end
  endtask

  // Result is due two edges after an accepted strobe
  always @(posedge clk_i)
  begin
    due_q    <= accept_q;
    accept_q <= rst_n_i & valid_i & ~clear_i;
  end

  always @(negedge clk_i)
  begin
    exec_out_t want;
    exec_out_t got;
    string     name;
    if (due_q)
    begin
      if (exp_q.size() == 0)
      begin
        $display("a result came out with no expected value queued");
        note_error();
      end
      else
      begin
        want = exp_q.pop_front();
        name = name_q.pop_front();
        got  = keep_live(result_o);
        checks++;
        if (got !== want)
        begin
          $display("error %s: expected %h actual %h", name, want, got);
          note_error();
        end
      end
    end
    else if (result_o.wb_valid || result_o.redirect || result_o.mem_req || result_o.mispredict)
    begin
      $display("result_o pulsed in %s while no instruction was due", cur_test);
      note_error();
    end
  end

  initial
  begin
    logic [2:0] f3;
    clk_i   = 1'b0;
    rst_n_i = 1'b0;
    instr_i = '0;
    pc_i    = '0;
    valid_i = 1'b0;
    clear_i = 1'b0;
    irq_i   = 1'b0;
    for (int i = 0; i < 32; i++)
      regs_m[i] = '0;
    ras_top_m = 0;
    ras_cnt_m = 0;
    uepc_m    = '0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    start_test("alu");
    for (int i = 0; i < 48; i++)
      issue(random_alu());
    finish_test();

    start_test("mul");
    for (int i = 0; i < 16; i++)
    begin
      load_random(5'd10);
      load_random(5'd11);
      issue(r_type(7'd1, 5'd11, 5'd10, 3'(i % 4), 5'd12));
    end
    finish_test();

    start_test("upper_and_branch");
    for (int i = 0; i < 6; i++)
    begin
      issue(u_type(20'(rand_bits(20)), 5'd6, OPC_LUI));
      issue(u_type(20'(rand_bits(20)), 5'd7, OPC_AUIPC));
    end
    for (int i = 0; i < 24; i++)
    begin
      f3 = 3'(i % 6);
      if (f3 >= 3'd2)
        f3 = f3 + 3'd2;  // Skip the two unused conditions
      load_random(5'd10);
      if (rand_bits(1))
        issue(i_type(12'd0, 5'd10, 3'd0, 5'd11, OPC_OP_IMM));  // Equal operands
      else
        load_random(5'd11);
      issue(b_type({12'(rand_bits(12)), 1'b0}, 5'd11, 5'd10, f3));
    end
    finish_test();

    start_test("jump");
    load_random(5'd5);
    issue(i_type(12'd0, 5'd5, 3'd0, 5'd0, OPC_JALR));  // Return with empty stack
    issue(j_type({20'(rand_bits(20)), 1'b0}, 5'd1));
    issue(i_type(12'd0, 5'd1, 3'd0, 5'd0, OPC_JALR));  // Matching return
    for (int i = 0; i < 6; i++)
    begin
      load_random(5'd10);
      issue(i_type(12'(rand_bits(12)), 5'd10, 3'd0, 5'(rand_bits(3)), OPC_JALR));
      issue(j_type({20'(rand_bits(20)), 1'b0}, 5'(rand_bits(3))));
    end
    issue(i_type(12'd0, 5'd1, 3'd0, 5'd0, OPC_JALR));
    finish_test();

    start_test("memory");
    for (int i = 0; i < 12; i++)
    begin
      f3 = 3'(i % 5);
      if (f3 >= 3'd3)
        f3 = f3 + 3'd1;  // LB LH LW LBU LHU
      load_random(5'd10);
      load_random(5'd11);
      issue(i_type(12'(rand_bits(12)), 5'd10, f3, 5'd12, OPC_LOAD));
      issue(s_type(12'(rand_bits(12)), 5'd11, 5'd10, 3'(i % 3)));
      issue(r_type(7'd0, 5'd0, 5'd12, 3'd0, 5'd13));  // x12 must be unchanged
    end
    finish_test();

    start_test("clear_and_trap");
    issue(i_type(12'd77, 5'd0, 3'd0, 5'd14, OPC_OP_IMM));
    issue_cleared(i_type(12'd5, 5'd0, 3'd0, 5'd14, OPC_OP_IMM));
    issue(r_type(7'd0, 5'd0, 5'd14, 3'd0, 5'd15));
    raise_irq({30'(rand_bits(30)), 2'b00});
    issue(MRET_INSTR);
    finish_test();

    $display("%0d tests run, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, total_errs);
    if ((total_errs == 0) && (tests_failed == 0))
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: source/rv32_core_slice.sv
`timescale 1ns/1ns

module rv32_core_slice
  import rv32_pkg::*;
#(
  parameter int XLEN      = 32,
  parameter int RAS_DEPTH = 4
)
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic [XLEN-1:0] instr_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic            valid_i,
  input  logic            clear_i,
  input  logic            irq_i,
  output exec_out_t       result_o,
  output logic [XLEN-1:0] uepc_o
);

  dec_bundle_t     dec;
  logic [4:0]      rs1_addr;
  logic [4:0]      rs2_addr;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic            rf_we;
  logic [4:0]      rf_waddr;
  logic [XLEN-1:0] rf_wdata;
  logic            ras_push;
  logic            ras_pop;
  logic [XLEN-1:0] ras_data;
  logic [XLEN-1:0] ras_top;

  // Trap return PC, MRET jumps back here
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      uepc_o <= '0;
    else if (irq_i)
      uepc_o <= pc_i;
  end

  rv32_decode #(.XLEN(XLEN)) u_decode (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .instr_i (instr_i),
    .pc_i    (pc_i),
    .valid_i (valid_i),
    .clear_i (clear_i),
    .dec_o   (dec)
  );

  rv32_regfile #(.XLEN(XLEN)) u_regfile (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (rf_we),
    .wr_addr_i  (rf_waddr),
    .wr_data_i  (rf_wdata)
  );

  rv32_ras #(.XLEN(XLEN), .RAS_DEPTH(RAS_DEPTH)) u_ras (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (ras_push),
    .pop_i       (ras_pop),
    .push_data_i (ras_data),
    .top_o       (ras_top)
  );

  rv32_execute #(.XLEN(XLEN)) u_execute (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .dec_i      (dec),
    .rs1_addr_o (rs1_addr),
    .rs2_addr_o (rs2_addr),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .rf_we_o    (rf_we),
    .rf_waddr_o (rf_waddr),
    .rf_wdata_o (rf_wdata),
    .ras_push_o (ras_push),
    .ras_pop_o  (ras_pop),
    .ras_data_o (ras_data),
    .ras_top_i  (ras_top),
    .uepc_i     (uepc_o),
    .result_o   (result_o)
  );

endmodule

// File: source/rv32_decode.sv
`timescale 1ns/1ns

module rv32_decode
  import rv32_pkg::*;
#(
  parameter int XLEN = 32
)
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic [XLEN-1:0] instr_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic            valid_i,
  input  logic            clear_i,
  output dec_bundle_t     dec_o
);

  typedef enum logic [2:0] {
    FMT_NONE,
    FMT_R,
    FMT_I,
    FMT_S,
    FMT_U,
    FMT_B,
    FMT_J
  } fmt_e;

  localparam logic [4:0] LINK_REG     = 5'd1;
  localparam logic [4:0] LINK_REG_ALT = 5'd5;

  opcode_e         opc;
  fmt_e            fmt;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [4:0]      rd;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [XLEN-1:0] i_imm;
  logic [XLEN-1:0] s_imm;
  logic [XLEN-1:0] b_imm;
  logic [XLEN-1:0] u_imm;
  logic [XLEN-1:0] j_imm;
  logic            rd_link;
  logic            rs1_link;
  logic            is_call;
  logic            is_ret;
  logic            is_mret;
  dec_bundle_t     dec_d;

  assign opc    = opcode_e'(instr_i[6:2]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rd     = instr_i[11:7];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];

  assign i_imm = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign s_imm = {{(XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign b_imm = {{(XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign u_imm = {instr_i[31:12], 12'b0};
  assign j_imm = {{(XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // Return stack hints, x1 and x5 count as link registers
  assign rd_link  = (rd == LINK_REG) | (rd == LINK_REG_ALT);
  assign rs1_link = (rs1 == LINK_REG) | (rs1 == LINK_REG_ALT);
  assign is_call  = rd_link & ((opc == OPC_JAL) | (opc == OPC_JALR));
  assign is_ret   = rs1_link & (opc == OPC_JALR);

  assign is_mret = (instr_i[31:20] == 12'h302) & (funct3 == 3'b000);

  always_comb
  begin
    case (opc)
      OPC_OP:                                     fmt = FMT_R;
      OPC_LOAD, OPC_OP_IMM, OPC_JALR, OPC_SYSTEM: fmt = FMT_I;
      OPC_STORE:                                  fmt = FMT_S;
      OPC_AUIPC, OPC_LUI:                         fmt = FMT_U;
      OPC_BRANCH:                                 fmt = FMT_B;
      OPC_JAL:                                    fmt = FMT_J;
      default:                                    fmt = FMT_NONE; // FENCE and unknown
    endcase
  end

  always_comb
  begin
    dec_d           = '0;
    dec_d.valid     = 1'b1;
    dec_d.alu_op    = ALU_ADD;
    dec_d.path      = PATH_ALU;
    dec_d.funct3    = funct3;
    dec_d.pc        = pc_i;
    dec_d.link_data = pc_i + 32'd4;
    dec_d.ras_push  = is_call;
    dec_d.ras_pop   = is_ret & ~(is_call & (rd == rs1)); // Same reg means push only
    case (fmt)
      FMT_R:
      begin
        dec_d.rs1    = rs1;
        dec_d.rs2    = rs2;
        dec_d.rd     = rd;
        dec_d.alu_op = alu_op_e'({funct7[5], funct3});
        dec_d.path   = funct7[0] ? PATH_MUL : PATH_ALU;
      end
      FMT_I:
      begin
        dec_d.rs1       = rs1;
        dec_d.rd        = rd;
        dec_d.imm       = i_imm;
        dec_d.imm_valid = 1'b1;
        case (opc)
          OPC_LOAD:   dec_d.path = PATH_MEM;
          OPC_OP_IMM: dec_d.alu_op = alu_op_e'({funct7[5] & (funct3 == 3'b101), funct3});
          OPC_JALR:
          begin
            dec_d.is_jalr = 1'b1;
            dec_d.is_link = 1'b1;
          end
          default:
          begin
            // SYSTEM, only MRET does anything
            dec_d.rs1  = '0;
            dec_d.rd   = '0;
            dec_d.mret = is_mret;
          end
        endcase
      end
      FMT_S:
      begin
        dec_d.rs1       = rs1;
        dec_d.rs2       = rs2;
        dec_d.imm       = s_imm;
        dec_d.imm_valid = 1'b1;
        dec_d.path      = PATH_MEM;
        dec_d.mem_write = 1'b1;
      end
      FMT_U:
      begin
        dec_d.rd        = rd;
        dec_d.imm       = (opc == OPC_AUIPC) ? u_imm + pc_i : u_imm; // x0 + imm in the ALU
        dec_d.imm_valid = 1'b1;
      end
      FMT_B:
      begin
        dec_d.rs1       = rs1;
        dec_d.rs2       = rs2;
        dec_d.imm       = b_imm;
        dec_d.is_branch = 1'b1;
      end
      FMT_J:
      begin
        dec_d.rd      = rd;
        dec_d.imm     = pc_i + j_imm; // Jump target
        dec_d.is_jal  = 1'b1;
        dec_d.is_link = 1'b1;
      end
      default:
      begin
        dec_d.ras_push = 1'b0;
        dec_d.ras_pop  = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      dec_o <= '0;
    else if (clear_i || !valid_i)
      dec_o.valid <= 1'b0; // Flush drops the incoming instruction
    else
      dec_o <= dec_d;
  end

endmodule

// File: source/rv32_execute.sv
`timescale 1ns/1ns

module rv32_execute
  import rv32_pkg::*;
#(
  parameter int XLEN = 32
)
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  dec_bundle_t     dec_i,
  output logic [4:0]      rs1_addr_o,
  output logic [4:0]      rs2_addr_o,
  input  logic [XLEN-1:0] rs1_data_i,
  input  logic [XLEN-1:0] rs2_data_i,
  output logic            rf_we_o,
  output logic [4:0]      rf_waddr_o,
  output logic [XLEN-1:0] rf_wdata_o,
  output logic            ras_push_o,
  output logic            ras_pop_o,
  output logic [XLEN-1:0] ras_data_o,
  input  logic [XLEN-1:0] ras_top_i,
  input  logic [XLEN-1:0] uepc_i,
  output exec_out_t       result_o
);

  logic [XLEN-1:0]          op_a;
  logic [XLEN-1:0]          op_b;
  logic [4:0]               shamt;
  logic [XLEN-1:0]          alu_res;
  logic                     mul_a_signed;
  logic                     mul_b_signed;
  logic signed [XLEN:0]     mul_a;
  logic signed [XLEN:0]     mul_b;
  logic signed [2*XLEN+1:0] mul_full;
  logic [XLEN-1:0]          mul_res;
  logic                     br_eq;
  logic                     br_lt;
  logic                     br_ltu;
  logic                     br_taken;
  logic [XLEN-1:0]          jalr_target;
  logic                     mispredict;
  exec_out_t                res_d;

  assign rs1_addr_o = dec_i.rs1;
  assign rs2_addr_o = dec_i.rs2;

  assign op_a  = rs1_data_i;
  assign op_b  = dec_i.imm_valid ? dec_i.imm : rs2_data_i;
  assign shamt = op_b[4:0];

  always_comb
  begin
    case (dec_i.alu_op)
      ALU_SUB:  alu_res = op_a - op_b;
      ALU_SLL:  alu_res = op_a << shamt;
      ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:  alu_res = op_a ^ op_b;
      ALU_SRL:  alu_res = op_a >> shamt;
      ALU_SRA:  alu_res = $signed(op_a) >>> shamt;
      ALU_OR:   alu_res = op_a | op_b;
      ALU_AND:  alu_res = op_a & op_b;
      default:  alu_res = op_a + op_b; // ADD, also LUI and AUIPC through x0
    endcase
  end

  // One extra bit per operand covers all four signedness mixes
  assign mul_a_signed = (dec_i.funct3[1:0] != 2'b11);
  assign mul_b_signed = (dec_i.funct3[1:0] == 2'b01);
  assign mul_a    = {mul_a_signed & op_a[XLEN-1], op_a};
  assign mul_b    = {mul_b_signed & op_b[XLEN-1], op_b};
  assign mul_full = mul_a * mul_b;
  assign mul_res  = (dec_i.funct3 == 3'b000) ? mul_full[XLEN-1:0] : mul_full[2*XLEN-1:XLEN];

  assign br_eq  = (rs1_data_i == rs2_data_i);
  assign br_lt  = ($signed(rs1_data_i) < $signed(rs2_data_i));
  assign br_ltu = (rs1_data_i < rs2_data_i);

  always_comb
  begin
    case (dec_i.funct3)
      3'b000:  br_taken = br_eq;
      3'b001:  br_taken = !br_eq;
      3'b100:  br_taken = br_lt;
      3'b101:  br_taken = !br_lt;
      3'b110:  br_taken = br_ltu;
      3'b111:  br_taken = !br_ltu;
      default: br_taken = 1'b0;
    endcase
  end

  assign jalr_target = (rs1_data_i + dec_i.imm) & ~{{(XLEN-1){1'b0}}, 1'b1};
  assign mispredict  = dec_i.is_jalr & (ras_top_i != jalr_target);

  assign ras_push_o = dec_i.valid & dec_i.ras_push;
  assign ras_pop_o  = dec_i.valid & dec_i.ras_pop;
  assign ras_data_o = dec_i.link_data;

  always_comb
  begin
    res_d = '0;
    if (dec_i.valid)
    begin
      res_d.wb_valid = (dec_i.rd != 5'd0) && (dec_i.path != PATH_MEM); // Loads never return
      res_d.wb_rd    = dec_i.rd;
      if (dec_i.is_link)
        res_d.wb_data = dec_i.link_data;
      else if (dec_i.path == PATH_MUL)
        res_d.wb_data = mul_res;
      else
        res_d.wb_data = alu_res;

      if (dec_i.mret)
        res_d.redirect_pc = uepc_i;
      else if (dec_i.is_jal)
        res_d.redirect_pc = dec_i.imm;
      else if (dec_i.is_jalr)
        res_d.redirect_pc = jalr_target;
      else
        res_d.redirect_pc = dec_i.pc + dec_i.imm; // Branch target
      res_d.redirect   = dec_i.mret | dec_i.is_jal | mispredict | (dec_i.is_branch & br_taken);
      res_d.mispredict = mispredict;

      res_d.mem_req   = (dec_i.path == PATH_MEM);
      res_d.mem_write = dec_i.mem_write;
      res_d.mem_addr  = rs1_data_i + dec_i.imm;
      res_d.mem_wdata = rs2_data_i;
      res_d.mem_size  = dec_i.funct3;
    end
  end

  // Write lands on the same edge that registers result_o
  assign rf_we_o    = res_d.wb_valid;
  assign rf_waddr_o = res_d.wb_rd;
  assign rf_wdata_o = res_d.wb_data;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      result_o <= '0;
    else
      result_o <= res_d;
  end

endmodule

// File: source/rv32_pkg.sv
package rv32_pkg;

  // Instruction bits 6 to 2
  typedef enum logic [4:0] {
    OPC_LOAD   = 5'b00000,
    OPC_FENCE  = 5'b00011,
    OPC_OP_IMM = 5'b00100,
    OPC_AUIPC  = 5'b00101,
    OPC_STORE  = 5'b01000,
    OPC_OP     = 5'b01100,
    OPC_LUI    = 5'b01101,
    OPC_BRANCH = 5'b11000,
    OPC_JALR   = 5'b11001,
    OPC_JAL    = 5'b11011,
    OPC_SYSTEM = 5'b11100
  } opcode_e;

  // Alternate bit on top of funct3
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_op_e;

  typedef enum logic [1:0] {
    PATH_ALU = 2'd0,
    PATH_MEM = 2'd1,
    PATH_MUL = 2'd2
  } path_e;

  typedef struct packed {
    logic        valid;
    alu_op_e     alu_op;
    path_e       path;
    logic [2:0]  funct3;      // Branch condition, mul variant or access size
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;         // JAL and AUIPC already hold pc plus offset
    logic        imm_valid;
    logic [31:0] pc;
    logic [31:0] link_data;
    logic        is_branch;
    logic        is_jal;
    logic        is_jalr;
    logic        is_link;
    logic        mem_write;
    logic        mret;
    logic        ras_push;
    logic        ras_pop;
  } dec_bundle_t;

  typedef struct packed {
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        mispredict;
    logic        mem_req;
    logic        mem_write;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [2:0]  mem_size;
  } exec_out_t;

endpackage

// File: source/rv32_ras.sv
`timescale 1ns/1ns

module rv32_ras #(
  parameter int XLEN      = 32,
  parameter int RAS_DEPTH = 4
)
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            push_i,
  input  logic            pop_i,
  input  logic [XLEN-1:0] push_data_i,
  output logic [XLEN-1:0] top_o
);

  localparam int PTR_W = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;

  logic [XLEN-1:0]  stack [RAS_DEPTH];
  logic [PTR_W-1:0] top_q;   // Index of current top
  logic [PTR_W:0]   count_q; // Valid entries, saturates at depth
  logic [PTR_W-1:0] top_inc;
  logic [PTR_W-1:0] top_dec;

  // Circular wrap, a push when full lands on the oldest entry
  assign top_inc = (top_q == PTR_W'(RAS_DEPTH - 1)) ? '0 : top_q + 1'b1;
  assign top_dec = (top_q == '0) ? PTR_W'(RAS_DEPTH - 1) : top_q - 1'b1;

  assign top_o = (count_q == '0) ? '0 : stack[top_q];

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      top_q   <= '0;
      count_q <= '0;
    end
    else if (push_i && pop_i)
    begin
      stack[top_q] <= push_data_i; // Replace top
      if (count_q == '0)
        count_q <= 1'b1;
    end
    else if (push_i)
    begin
      stack[top_inc] <= push_data_i;
      top_q          <= top_inc;
      if (count_q != (PTR_W+1)'(RAS_DEPTH))
        count_q <= count_q + 1'b1;
    end
    else if (pop_i && (count_q != '0))
    begin
      top_q   <= top_dec;
      count_q <= count_q - 1'b1;
    end
  end

endmodule

// File: source/rv32_regfile.sv
`timescale 1ns/1ns

module rv32_regfile #(
  parameter int XLEN = 32
)
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic [4:0]      rs1_addr_i,
  input  logic [4:0]      rs2_addr_i,
  output logic [XLEN-1:0] rs1_data_o,
  output logic [XLEN-1:0] rs2_data_o,
  input  logic            we_i,
  input  logic [4:0]      wr_addr_i,
  input  logic [XLEN-1:0] wr_data_i
);

  logic [XLEN-1:0] regs [32];

  // Reads are combinational, x0 is never written so it stays zero
  assign rs1_data_o = regs[rs1_addr_i];
  assign rs2_data_o = regs[rs2_addr_i];

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (we_i && (wr_addr_i != 5'd0))
    begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

endmodule

// File: tb.f
source/rv32_pkg.sv
source/rv32_decode.sv
source/rv32_regfile.sv
source/rv32_ras.sv
source/rv32_execute.sv
source/rv32_core_slice.sv
dv/tb_rv32_core_slice.sv
